//--- vlog.f
logic/loader_pkg.sv
logic/key_translate.sv
logic/loader_ctrl.sv
logic/inst_assembler.sv
logic/calc_unit.sv
logic/data_loader.sv
tb/clk_gen.sv
tb/data_loader_sva.sv
tb/data_loader_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= data_loader_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --Wno-fatal
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/data_loader_tb.sv
`timescale 1ns/1ps

module data_loader_tb;

    logic                               clk_100;
    logic                               rst;
    logic [loader_pkg::KEY_RAW_W-1:0]   key_ps2;
    logic                               wen_key_ps2;
    logic [loader_pkg::KEY_RAW_W-1:0]   key_uart;
    logic                               wen_key_uart;
    loader_pkg::mode_t                  mode;
    logic                               mode_flag;
    logic [loader_pkg::INST_ADDR_W-1:0] inst_addr;
    logic [loader_pkg::INST_W-1:0]      inst_write;
    logic                               inst_wen;
    logic [loader_pkg::RESULT_W-1:0]    alu_out;
    logic                               result_ready;
    logic                               ap_start;

    logic [31:0] lfsr = 32'h62c8;
    string       cur_test;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [15:0] model_word;
    logic [11:0] model_addr;

    // set 2 make codes of 0..9 and a..f
    logic [7:0] hex_scan [16] = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d,
                                  8'h3e, 8'h46, 8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b};
    // space, shifts, plus, minus, i, l, esc
    logic [7:0] ps2_junk [8] = '{8'h29, 8'h12, 8'h59, 8'h55, 8'h4e, 8'h43, 8'h4b, 8'h76};
    logic [7:0] uart_junk [4] = '{8'h20, 8'h78, 8'h47, 8'h2b};  // ' ', x, G, +

    clk_gen clocks (.clk_100(clk_100), .rst(rst));

    data_loader dut0 (
        .clk_100      (clk_100),
        .rst          (rst),
        .key_ps2      (key_ps2),
        .wen_key_ps2  (wen_key_ps2),
        .key_uart     (key_uart),
        .wen_key_uart (wen_key_uart),
        .mode         (mode),
        .mode_flag    (mode_flag),
        .inst_addr    (inst_addr),
        .inst_write   (inst_write),
        .inst_wen     (inst_wen),
        .alu_out      (alu_out),
        .result_ready (result_ready),
        .ap_start     (ap_start)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] hex_ascii(input logic [3:0] d, input logic upper);
        if (d < 4'd10) begin
            return 8'h30 + 8'(d);
        end
        return (upper ? 8'h41 : 8'h61) + 8'(d) - 8'd10;
    endfunction

    function automatic logic [7:0] hex_key(input logic uart, input logic [3:0] d);
        return uart ? hex_ascii(d, rand_bits(1) != 0) : hex_scan[d];
    endfunction

    function automatic logic [7:0] junk_key(input logic uart);
        return uart ? uart_junk[rand_bits(2)] : ps2_junk[rand_bits(3)];
    endfunction

    // ^ and * are the shifted 6 and 8
    function automatic logic [7:0] op_key(input logic [1:0] op);
        case (op)
            2'd0:    return hex_scan[6];
            2'd1:    return 8'h55;
            2'd2:    return 8'h4e;
            default: return hex_scan[8];
        endcase
    endfunction

    function automatic logic [7:0] alu_model(input logic [1:0] op, input logic [3:0] a,
                                             input logic [3:0] b);
        logic [7:0] wa;
        logic [7:0] wb;
        wa = {4'h0, a};
        wb = {4'h0, b};
        case (op)
            2'd0:    return wa ^ wb;
            2'd1:    return wa + wb;
            2'd2:    return wa - wb;
            default: return wa * wb;
        endcase
    endfunction

    function automatic logic pulse_level(input string name);
        case (name)
            "mode_flag": return mode_flag;
            "ap_start":  return ap_start;
            default:     return result_ready;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // six idle cycles ahead of every strobe
    task automatic send_key(input logic uart, input logic [7:0] b);
        repeat (6) @(posedge clk_100);
        if (uart) begin
            key_uart     <= b;
            wen_key_uart <= 1'b1;
        end else begin
            key_ps2     <= b;
            wen_key_ps2 <= 1'b1;
        end
        @(posedge clk_100);
        wen_key_uart <= 1'b0;
        wen_key_ps2  <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_100);
    endtask

    task automatic wait_pulse(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk_100);
            n++;
        end while (!pulse_level(name) && n < 20);
        if (!pulse_level(name)) begin
            $display("%s: %s never pulsed within 20 cycles", cur_test, name);
            test_errors++;
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        do begin
            @(negedge clk_100);
            n++;
        end while (rst !== 1'b0 && n < 10);
        if (rst !== 1'b0) begin
            $display("%s: reset was never released", cur_test);
            test_errors++;
        end
    endtask

    task automatic enter_words(input logic uart, input int n_words);
        logic [3:0] d;
        repeat (n_words) begin
            model_word = '0;
            repeat (4) begin
                if (rand_bits(1) != 0) begin
                    send_key(uart, junk_key(uart));  // must be ignored
                end
                d = rand_bits(4);
                send_key(uart, hex_key(uart, d));
                model_word = {model_word[11:0], d};
            end
            idle(6);
            check("word", model_word, inst_write);
            check("inst_wen", 1, inst_wen);
            d = rand_bits(4);
            send_key(uart, hex_key(uart, d));  // one digit too many
            idle(6);
            check("word after fifth digit", model_word, inst_write);
            send_key(uart, uart ? 8'h0a : 8'h5a);
            idle(6);
            model_addr = model_addr + 12'd1;
            check("address", model_addr, inst_addr);
            check("word after enter", 0, inst_write);
        end
    endtask

    task automatic run_calc(input logic [1:0] op);
        logic [3:0] a;
        logic [3:0] b;
        a = rand_bits(4);
        b = rand_bits(4);
        send_key(1'b0, hex_scan[10]);
        send_key(1'b0, 8'h5a);
        wait_pulse("mode_flag");
        check("calculator mode", loader_pkg::MODE_CALC, mode);
        send_key(1'b0, hex_scan[a]);
        send_key(1'b0, (rand_bits(1) != 0) ? 8'h12 : 8'h59);
        send_key(1'b0, op_key(op));
        send_key(1'b0, hex_scan[b]);
        wait_pulse("result_ready");
        check("alu_out", alu_model(op, a, b), alu_out);
    endtask

    task automatic leave_entry(input logic uart);
        send_key(uart, uart ? ((rand_bits(1) != 0) ? 8'h52 : 8'h72) : 8'h2d);
        wait_pulse("ap_start");
        idle(6);
        model_addr = loader_pkg::INST_BASE_ADDR;
        check("mode after run", loader_pkg::MODE_IDLE, mode);
        check("address after run", model_addr, inst_addr);
    endtask

    initial begin
        key_ps2      = '0;
        wen_key_ps2  = 1'b0;
        key_uart     = '0;
        wen_key_uart = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        model_addr   = loader_pkg::INST_BASE_ADDR;

        start_test("reset");
        wait_reset();
        check("mode", loader_pkg::MODE_IDLE, mode);
        check("address", model_addr, inst_addr);
        check("word", 0, inst_write);
        check("inst_wen", 0, inst_wen);
        check("alu_out", 0, alu_out);
        check("pulses", 0, {mode_flag, ap_start, result_ready});
        finish_test();

        start_test("mode select");
        send_key(1'b0, ps2_junk[rand_bits(2)]);  // space, shift or plus picks nothing
        send_key(1'b0, 8'h5a);
        wait_pulse("mode_flag");
        check("mode after other key", loader_pkg::MODE_IDLE, mode);
        send_key(1'b0, 8'h43);
        send_key(1'b0, 8'h5a);
        wait_pulse("mode_flag");
        check("mode after i", loader_pkg::MODE_INST, mode);
        finish_test();

        start_test("ps2 entry");
        enter_words(1'b0, 4);
        finish_test();

        start_test("run");
        leave_entry(1'b0);
        finish_test();

        start_test("uart entry");
        send_key(1'b0, 8'h4b);
        send_key(1'b0, 8'h5a);
        wait_pulse("mode_flag");
        check("mode after l", loader_pkg::MODE_UART, mode);
        enter_words(1'b1, 4);
        leave_entry(1'b1);
        finish_test();

        start_test("calculator");
        for (int op = 0; op < 4; op++) begin
            run_calc(2'(op));
        end
        finish_test();

        if (dut0.sva0.fail_count != 0) begin
            $display("%0d assertion failures in the bound checker", dut0.sva0.fail_count);
            tests_failed++;
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/data_loader_sva.sv
`timescale 1ns/1ps

module data_loader_sva (
    input logic              clk_100,
    input logic              rst,
    input loader_pkg::mode_t mode,
    input logic              mode_flag,
    input logic              inst_wen,
    input logic              result_ready,
    input logic              ap_start
);

    int fail_count = 0;  // assertion failures so far

    ap_start_pulse: assert property (@(posedge clk_100) disable iff (rst) ap_start |=> !ap_start)
        else begin
            fail_count++;
            $error("ap_start stayed high for more than one cycle");
        end

    result_ready_pulse: assert property (@(posedge clk_100) disable iff (rst)
        result_ready |=> !result_ready)
        else begin
            fail_count++;
            $error("result_ready stayed high for more than one cycle");
        end

    mode_flag_pulse: assert property (@(posedge clk_100) disable iff (rst)
        mode_flag |=> !mode_flag)
        else begin
            fail_count++;
            $error("mode_flag stayed high for more than one cycle");
        end

    // a full word only exists in one of the entry modes
    wen_in_entry: assert property (@(posedge clk_100) disable iff (rst)
        inst_wen |-> (mode == loader_pkg::MODE_INST || mode == loader_pkg::MODE_UART))
        else begin
            fail_count++;
            $error("inst_wen high outside an entry mode");
        end

endmodule

bind data_loader data_loader_sva sva0 (
    .clk_100      (clk_100),
    .rst          (rst),
    .mode         (mode),
    .mode_flag    (mode_flag),
    .inst_wen     (inst_wen),
    .result_ready (result_ready),
    .ap_start     (ap_start)
);

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_100,
    output logic rst
);

    initial begin
        clk_100 = 1'b0;
        forever #4 clk_100 = ~clk_100;  // 8 ns period
    end

    // reset held for two rising edges, released on the second
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_100);
        rst <= 1'b0;
    end

endmodule

//--- logic/data_loader.sv
`timescale 1ns/1ps

module data_loader (
    input  logic                               clk_100,
    input  logic                               rst,
    input  logic [loader_pkg::KEY_RAW_W-1:0]   key_ps2,
    input  logic                               wen_key_ps2,
    input  logic [loader_pkg::KEY_RAW_W-1:0]   key_uart,
    input  logic                               wen_key_uart,
    output loader_pkg::mode_t                  mode,
    output logic                               mode_flag,
    output logic [loader_pkg::INST_ADDR_W-1:0] inst_addr,
    output logic [loader_pkg::INST_W-1:0]      inst_write,
    output logic                               inst_wen,
    output logic [loader_pkg::RESULT_W-1:0]    alu_out,
    output logic                               result_ready,
    output logic                               ap_start
);

    loader_pkg::key_evt_t  ps2_evt;
    loader_pkg::key_evt_t  uart_evt;
    loader_pkg::inst_cmd_t inst_cmd;
    loader_pkg::calc_cmd_t calc_cmd;
    logic                  word_full;

    key_translate #(.keymap(loader_pkg::KEYMAP_PS2)) ps2_keys (
        .clk_100 (clk_100),
        .rst     (rst),
        .key     (key_ps2),
        .wen     (wen_key_ps2),
        .evt     (ps2_evt)
    );

    key_translate #(.keymap(loader_pkg::KEYMAP_UART)) uart_keys (
        .clk_100 (clk_100),
        .rst     (rst),
        .key     (key_uart),
        .wen     (wen_key_uart),
        .evt     (uart_evt)
    );

    loader_ctrl ctrl (
        .clk_100   (clk_100),
        .rst       (rst),
        .ps2_evt   (ps2_evt),
        .uart_evt  (uart_evt),
        .word_full (word_full),
        .inst_cmd  (inst_cmd),
        .calc_cmd  (calc_cmd),
        .mode      (mode),
        .mode_flag (mode_flag),
        .ap_start  (ap_start)
    );

    inst_assembler inst_asm (
        .clk_100    (clk_100),
        .rst        (rst),
        .cmd        (inst_cmd),
        .inst_write (inst_write),
        .inst_addr  (inst_addr),
        .inst_wen   (inst_wen),
        .word_full  (word_full)
    );

    calc_unit calc (
        .clk_100      (clk_100),
        .rst          (rst),
        .cmd          (calc_cmd),
        .alu_out      (alu_out),
        .result_ready (result_ready)
    );

endmodule

//--- logic/calc_unit.sv
`timescale 1ns/1ps

module calc_unit (
    input  logic                              clk_100,
    input  logic                              rst,
    input  loader_pkg::calc_cmd_t             cmd,
    output logic [loader_pkg::RESULT_W-1:0]   alu_out,
    output logic                              result_ready
);

    logic [loader_pkg::OPND_W-1:0]   opnd_a;
    loader_pkg::alu_op_t             alu_op;
    logic [loader_pkg::RESULT_W-1:0] ext_a;
    logic [loader_pkg::RESULT_W-1:0] ext_b;
    logic [loader_pkg::RESULT_W-1:0] result;
    logic                            done;

    // operands widened before the arithmetic
    assign ext_a = loader_pkg::RESULT_W'(opnd_a);
    assign ext_b = loader_pkg::RESULT_W'(cmd.digit);

    always_comb begin
        case (alu_op)
            loader_pkg::ALU_XOR: result = ext_a ^ ext_b;
            loader_pkg::ALU_ADD: result = ext_a + ext_b;
            loader_pkg::ALU_SUB: result = ext_a - ext_b;  // wraps mod 256
            default:             result = ext_a * ext_b;
        endcase
    end

    always_ff @(posedge clk_100) begin
        if (cmd.load_a) begin
            opnd_a <= cmd.digit;
        end
        if (cmd.load_op) begin
            alu_op <= cmd.op;
        end
    end

    always_ff @(posedge clk_100) begin
        if (rst) begin
            alu_out      <= '0;
            done         <= 1'b0;
            result_ready <= 1'b0;
        end else begin
            done         <= cmd.load_b;
            result_ready <= done;     // one cycle after the result lands
            if (cmd.load_b) begin
                alu_out <= result;
            end
        end
    end

endmodule

//--- logic/inst_assembler.sv
`timescale 1ns/1ps

module inst_assembler (
    input  logic                                clk_100,
    input  logic                                rst,
    input  loader_pkg::inst_cmd_t               cmd,
    output logic [loader_pkg::INST_W-1:0]       inst_write,
    output logic [loader_pkg::INST_ADDR_W-1:0]  inst_addr,
    output logic                                inst_wen,
    output logic                                word_full
);

    logic [loader_pkg::NIBBLE_CNT_W-1:0] nibble_cnt;

    always_ff @(posedge clk_100) begin
        if (rst) begin
            inst_write <= '0;
            inst_addr  <= loader_pkg::INST_BASE_ADDR;
            nibble_cnt <= '0;
        end else if (cmd.rewind) begin
            // back to the start of the program
            inst_write <= '0;
            inst_addr  <= loader_pkg::INST_BASE_ADDR;
            nibble_cnt <= '0;
        end else if (cmd.commit) begin
            inst_write <= '0;
            inst_addr  <= inst_addr + 1'b1;
            nibble_cnt <= '0;
        end else if (cmd.push && !word_full) begin
            // newest digit enters at the low end
            inst_write <= {inst_write[loader_pkg::INST_W-loader_pkg::NIBBLE_W-1:0], cmd.nibble};
            nibble_cnt <= nibble_cnt + 1'b1;
        end
    end

    assign word_full = (nibble_cnt == loader_pkg::NIBBLE_CNT_W'(loader_pkg::INST_NIBBLES));
    assign inst_wen  = word_full;  // word is ready to be written

endmodule

//--- logic/loader_ctrl.sv
`timescale 1ns/1ps

module loader_ctrl (
    input  logic                  clk_100,
    input  logic                  rst,
    input  loader_pkg::key_evt_t  ps2_evt,
    input  loader_pkg::key_evt_t  uart_evt,
    input  logic                  word_full,
    output loader_pkg::inst_cmd_t inst_cmd,
    output loader_pkg::calc_cmd_t calc_cmd,
    output loader_pkg::mode_t     mode,
    output logic                  mode_flag,
    output logic                  ap_start
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_I_ENTRY,
        ST_L_ENTRY,
        ST_A_OPND_A,
        ST_A_SHIFT,
        ST_A_OPER,
        ST_A_OPND_B
    } state_t;

    state_t                state;
    state_t                state_next;
    loader_pkg::key_code_t prev_code;
    loader_pkg::key_evt_t  entry_evt;
    loader_pkg::inst_cmd_t inst_cmd_next;
    loader_pkg::calc_cmd_t calc_cmd_next;
    logic                  mode_flag_next;
    logic                  ap_start_next;
    logic                  ps2_hex;
    logic                  entry_hex;

    // L mode listens to the uart, everything else to the keyboard
    assign entry_evt = (state == ST_L_ENTRY) ? uart_evt : ps2_evt;
    assign ps2_hex   = ps2_evt.stb && !ps2_evt.code[4];
    assign entry_hex = entry_evt.stb && !entry_evt.code[4];

    always_comb begin
        state_next     = state;
        inst_cmd_next  = '0;
        calc_cmd_next  = '0;
        mode_flag_next = 1'b0;
        ap_start_next  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (ps2_evt.stb && ps2_evt.code == loader_pkg::KEY_ENTER) begin
                    mode_flag_next       = 1'b1;
                    inst_cmd_next.rewind = 1'b1;
                    case (prev_code)
                        loader_pkg::KEY_MODE_I: state_next = ST_I_ENTRY;
                        loader_pkg::KEY_MODE_L: state_next = ST_L_ENTRY;
                        loader_pkg::KEY_MODE_A: state_next = ST_A_OPND_A;
                        default:                state_next = ST_IDLE;
                    endcase
                end
            end
            ST_I_ENTRY, ST_L_ENTRY: begin
                if (entry_hex && !word_full) begin
                    inst_cmd_next.push   = 1'b1;
                    inst_cmd_next.nibble = entry_evt.code[3:0];
                end else if (entry_evt.stb && entry_evt.code == loader_pkg::KEY_ENTER &&
                             word_full) begin
                    inst_cmd_next.commit = 1'b1;
                end else if (entry_evt.stb && entry_evt.code == loader_pkg::KEY_RUN) begin
                    inst_cmd_next.rewind = 1'b1;
                    ap_start_next        = 1'b1;
                    state_next           = ST_IDLE;
                end
            end
            ST_A_OPND_A: begin
                if (ps2_hex) begin
                    calc_cmd_next.load_a = 1'b1;
                    calc_cmd_next.digit  = ps2_evt.code[3:0];
                    state_next           = ST_A_SHIFT;
                end
            end
            ST_A_SHIFT: begin
                if (ps2_evt.stb && (ps2_evt.code == loader_pkg::KEY_LSHIFT ||
                                    ps2_evt.code == loader_pkg::KEY_RSHIFT)) begin
                    state_next = ST_A_OPER;
                end
            end
            ST_A_OPER: begin
                if (ps2_evt.stb) begin
                    // shift is held, so 6 and 8 stand for ^ and *
                    case (ps2_evt.code)
                        loader_pkg::KEY_CARET: calc_cmd_next.op = loader_pkg::ALU_XOR;
                        loader_pkg::KEY_PLUS:  calc_cmd_next.op = loader_pkg::ALU_ADD;
                        loader_pkg::KEY_MINUS: calc_cmd_next.op = loader_pkg::ALU_SUB;
                        loader_pkg::KEY_STAR:  calc_cmd_next.op = loader_pkg::ALU_MUL;
                        default:               calc_cmd_next.op = loader_pkg::ALU_XOR;
                    endcase
                    if (ps2_evt.code == loader_pkg::KEY_CARET ||
                        ps2_evt.code == loader_pkg::KEY_PLUS ||
                        ps2_evt.code == loader_pkg::KEY_MINUS ||
                        ps2_evt.code == loader_pkg::KEY_STAR) begin
                        calc_cmd_next.load_op = 1'b1;
                        state_next            = ST_A_OPND_B;
                    end
                end
            end
            ST_A_OPND_B: begin
                if (ps2_hex) begin
                    calc_cmd_next.load_b = 1'b1;
                    calc_cmd_next.digit  = ps2_evt.code[3:0];
                    state_next           = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            ST_I_ENTRY: mode = loader_pkg::MODE_INST;
            ST_L_ENTRY: mode = loader_pkg::MODE_UART;
            ST_A_OPND_A, ST_A_SHIFT, ST_A_OPER, ST_A_OPND_B: mode = loader_pkg::MODE_CALC;
            default:    mode = loader_pkg::MODE_IDLE;
        endcase
    end

    always_ff @(posedge clk_100) begin
        if (rst) begin
            state     <= ST_IDLE;
            prev_code <= loader_pkg::KEY_NONE;
            inst_cmd  <= '0;
            calc_cmd  <= '0;
            mode_flag <= 1'b0;
            ap_start  <= 1'b0;
        end else begin
            state     <= state_next;
            inst_cmd  <= inst_cmd_next;
            calc_cmd  <= calc_cmd_next;
            mode_flag <= mode_flag_next;
            ap_start  <= ap_start_next;
            if (ps2_evt.stb) begin
                prev_code <= ps2_evt.code;  // mode key waits here for enter
            end
        end
    end

endmodule

//--- logic/key_translate.sv
`timescale 1ns/1ps

module key_translate #(
    parameter loader_pkg::keymap_t keymap = loader_pkg::KEYMAP_PS2
) (
    input  logic                               clk_100,
    input  logic                               rst,
    input  logic [loader_pkg::KEY_RAW_W-1:0]   key,
    input  logic                               wen,
    output loader_pkg::key_evt_t               evt
);

    loader_pkg::key_code_t code;

    // make codes from scan code set 2
    function automatic loader_pkg::key_code_t ps2_lookup(
        input logic [loader_pkg::KEY_RAW_W-1:0] scan
    );
        case (scan)
            8'h45: return 5'h00;
            8'h16: return 5'h01;
            8'h1e: return 5'h02;
            8'h26: return 5'h03;
            8'h25: return 5'h04;
            8'h2e: return 5'h05;
            8'h36: return 5'h06;
            8'h3d: return 5'h07;
            8'h3e: return 5'h08;
            8'h46: return 5'h09;
            8'h1c: return 5'h0a;
            8'h32: return 5'h0b;
            8'h21: return 5'h0c;
            8'h23: return 5'h0d;
            8'h24: return 5'h0e;
            8'h2b: return 5'h0f;
            8'h29: return loader_pkg::KEY_SPACE;
            8'h5a: return loader_pkg::KEY_ENTER;
            8'h12: return loader_pkg::KEY_LSHIFT;
            8'h59: return loader_pkg::KEY_RSHIFT;
            8'h55: return loader_pkg::KEY_PLUS;   // = / + key
            8'h4e: return loader_pkg::KEY_MINUS;
            8'h2d: return loader_pkg::KEY_RUN;    // r
            8'h43: return loader_pkg::KEY_MODE_I; // i
            8'h4b: return loader_pkg::KEY_MODE_L; // l
            default: return loader_pkg::KEY_NONE;
        endcase
    endfunction

    function automatic loader_pkg::key_code_t uart_lookup(
        input logic [loader_pkg::KEY_RAW_W-1:0] ascii
    );
        if (ascii >= 8'h30 && ascii <= 8'h39) begin
            return {1'b0, ascii[3:0]};         // '0'..'9'
        end else if ((ascii >= 8'h41 && ascii <= 8'h46) ||
                     (ascii >= 8'h61 && ascii <= 8'h66)) begin
            return {1'b0, ascii[3:0] + 4'd9};  // a..f either case
        end
        case (ascii)
            8'h20: return loader_pkg::KEY_SPACE;
            8'h0a: return loader_pkg::KEY_ENTER;  // line feed
            8'h52, 8'h72: return loader_pkg::KEY_RUN;
            default: return loader_pkg::KEY_NONE;
        endcase
    endfunction

    assign code = (keymap == loader_pkg::KEYMAP_PS2) ? ps2_lookup(key) : uart_lookup(key);

    always_ff @(posedge clk_100) begin
        if (rst) begin
            evt.stb  <= 1'b0;
            evt.code <= loader_pkg::KEY_NONE;
        end else begin
            evt.stb  <= wen;
            evt.code <= wen ? code : loader_pkg::KEY_NONE;
        end
    end

endmodule

//--- logic/loader_pkg.sv
package loader_pkg;

    // widths
    localparam int KEY_RAW_W    = 8;
    localparam int KEY_CODE_W   = 5;
    localparam int NIBBLE_W     = 4;
    localparam int INST_W       = 16;
    localparam int INST_NIBBLES = 4;
    localparam int NIBBLE_CNT_W = 3;   // counts 0..INST_NIBBLES
    localparam int INST_ADDR_W  = 12;
    localparam int OPND_W       = 4;
    localparam int RESULT_W     = 8;

    localparam logic [INST_ADDR_W-1:0] INST_BASE_ADDR = 12'd31;

    // bit 4 clear means hex digit in bits 3..0
    typedef logic [KEY_CODE_W-1:0] key_code_t;

    localparam key_code_t KEY_SPACE  = 5'h10;
    localparam key_code_t KEY_ENTER  = 5'h11;
    localparam key_code_t KEY_LSHIFT = 5'h12;
    localparam key_code_t KEY_RSHIFT = 5'h13;
    localparam key_code_t KEY_PLUS   = 5'h15;
    localparam key_code_t KEY_MINUS  = 5'h16;
    localparam key_code_t KEY_RUN    = 5'h18;
    localparam key_code_t KEY_MODE_I = 5'h19;
    localparam key_code_t KEY_MODE_L = 5'h1a;
    localparam key_code_t KEY_NONE   = 5'h1f;

    // hex keys with a second meaning
    localparam key_code_t KEY_CARET  = 5'h06;  // shifted 6
    localparam key_code_t KEY_STAR   = 5'h08;  // shifted 8
    localparam key_code_t KEY_MODE_A = 5'h0a;  // hex a picks the calculator

    typedef struct packed {
        logic      stb;
        key_code_t code;
    } key_evt_t;

    typedef enum logic {KEYMAP_PS2, KEYMAP_UART} keymap_t;

    typedef enum logic [2:0] {
        MODE_INST = 3'd0,
        MODE_UART = 3'd1,
        MODE_CALC = 3'd2,
        MODE_IDLE = 3'd4
    } mode_t;

    typedef enum logic [1:0] {
        ALU_XOR = 2'd0,
        ALU_ADD = 2'd1,
        ALU_SUB = 2'd2,
        ALU_MUL = 2'd3
    } alu_op_t;

    typedef struct packed {
        logic                push;
        logic [NIBBLE_W-1:0] nibble;
        logic                commit;
        logic                rewind;
    } inst_cmd_t;

    typedef struct packed {
        logic              load_a;
        logic              load_op;
        logic              load_b;
        logic [OPND_W-1:0] digit;
        alu_op_t           op;
    } calc_cmd_t;

endpackage
